//--- ex_stage.f
hw/ex_isa_pkg.sv
hw/ex_mem_pkg.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_lsu.sv
hw/ex_stage.sv
test/tb_clock_gen.sv
test/ex_stage_properties.sv
test/ex_stage_tb.sv

//--- hw/ex_alu.sv
/*
 * Integer ALU: add/sub, logic, shifts and set-less-than
 */

`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_isa_pkg::*;
(
  input  ex_op_e op_i,
  input  xlen_t  a_i,
  input  xlen_t  b_i,
  output xlen_t  r_o
);

  // Only the low five bits shift
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb
  begin
    case (op_i)
      ADD:
        r_o = a_i + b_i;
      SUB:
        r_o = a_i - b_i;
      AND:
        r_o = a_i & b_i;
      OR:
        r_o = a_i | b_i;
      XOR:
        r_o = a_i ^ b_i;
      SLL:
        r_o = a_i << shamt;
      SRL:
        r_o = a_i >> shamt;
      SRA:
        r_o = xlen_t'($signed(a_i) >>> shamt);
      // Compares return 0 or 1
      SLT:
        r_o = {31'b0, lt_signed};
      SLTU:
        r_o = {31'b0, lt_unsigned};
      default:
        r_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/ex_branch.sv
/*
 * Branch unit: condition check for conditional branches, jump target and link
 */

`timescale 1ns/1ps
`default_nettype none

module ex_branch
  import ex_isa_pkg::*;
(
  input  ex_op_e op_i,
  input  addr_t  pc_i,
  input  xlen_t  imm_i,
  input  xlen_t  a_i,
  input  xlen_t  b_i,
  output logic   taken_o,
  output addr_t  target_o,
  output xlen_t  link_o
);

  logic  eq;
  logic  lt_signed;
  logic  lt_unsigned;
  addr_t jalr_sum;

  assign eq          = a_i == b_i;
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb
  begin
    case (op_i)
      BEQ:       taken_o = eq;
      BNE:       taken_o = ~eq;
      BLT:       taken_o = lt_signed;
      BGE:       taken_o = ~lt_signed;
      BLTU:      taken_o = lt_unsigned;
      BGEU:      taken_o = ~lt_unsigned;
      JAL, JALR: taken_o = 1'b1;
      default:   taken_o = 1'b0;
    endcase
  end

  // JALR target is register relative with bit 0 dropped
  assign jalr_sum = a_i + imm_i;

  always_comb
  begin
    if (op_i == JALR)
      target_o = {jalr_sum[31:1], 1'b0};
    else
      target_o = pc_i + imm_i;
  end

  assign link_o = pc_i + xlen_t'(INSN_BYTES);

endmodule

`default_nettype wire

//--- hw/ex_isa_pkg.sv
/*
 * Execute stage ISA definitions: operations, decoded input and result record
 */

`default_nettype none

package ex_isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // Link increment for JAL/JALR
  localparam int unsigned INSN_BYTES = 4;

  typedef enum logic [4:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
    BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
    LB, LH, LW, LBU, LHU, SB, SH, SW
  } ex_op_e;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_BRANCH,
    UNIT_LSU
  } ex_unit_e;

  typedef struct packed {
    ex_op_e   op;
    addr_t    pc;
    xlen_t    imm;
    reg_idx_t rd;
    logic     use_imm_b;
    logic     bypass_a;
    logic     bypass_b;
  } ex_decoded_t;

  typedef struct packed {
    xlen_t    value;
    reg_idx_t rd;
    addr_t    pc;
    logic     misaligned;
  } ex_result_t;

  // Unit that executes a given operation
  function automatic ex_unit_e ex_unit_of(ex_op_e op);
    case (op)
      ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU: return UNIT_ALU;
      BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR:        return UNIT_BRANCH;
      default:                                          return UNIT_LSU;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hw/ex_lsu.sv
/*
 * Load/store unit: address and alignment check, store lane placement,
 * data-memory handshake and load extraction
 */

`timescale 1ns/1ps
`default_nettype none

module ex_lsu
  import ex_isa_pkg::*;
  import ex_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  ex_op_e    op_i,
  input  xlen_t     base_i,
  input  xlen_t     offset_i,
  input  xlen_t     wdata_i,
  output logic      done_o,
  output logic      misaligned_o,
  output xlen_t     rdata_o,
  output logic      dmem_valid_o,
  input  logic      dmem_ready_i,
  output dmem_req_t dmem_req_o,
  input  logic      dmem_rvalid_i,
  input  xlen_t     dmem_rdata_i
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_RESP, DONE} lsu_state_e;

  lsu_state_e state_q;
  lsu_state_e state_d;
  ex_op_e     op_q;
  logic       misaligned_q;
  xlen_t      rdata_q;
  dmem_req_t  req_q;
  addr_t      addr;
  mem_size_e  size;
  logic       is_store;
  logic       misaligned;
  logic       launch;
  xlen_t      lane_wdata;
  dmem_be_t   lane_be;

  function automatic xlen_t load_extract(ex_op_e op, logic [1:0] lane, xlen_t word);
    xlen_t shifted;
    shifted = word >> {lane, 3'b000};
    case (op)
      LB:      return {{24{shifted[7]}}, shifted[7:0]};
      LBU:     return {24'b0, shifted[7:0]};
      LH:      return {{16{shifted[15]}}, shifted[15:0]};
      LHU:     return {16'b0, shifted[15:0]};
      default: return word;
    endcase
  endfunction

  assign addr       = base_i + offset_i;
  assign size       = (op_i inside {LB, LBU, SB}) ? SIZE_BYTE :
                      (op_i inside {LH, LHU, SH}) ? SIZE_HALF : SIZE_WORD;
  assign is_store   = op_i inside {SB, SH, SW};
  assign misaligned = is_misaligned(addr, size);
  assign launch     = (state_q == IDLE) && start_i;

  // Replicate store data so every lane sees it
  always_comb
  begin
    case (size)
      SIZE_BYTE:
      begin
        lane_wdata = {4{wdata_i[7:0]}};
        lane_be    = dmem_be_t'(1) << addr[1:0];
      end
      SIZE_HALF:
      begin
        lane_wdata = {2{wdata_i[15:0]}};
        lane_be    = addr[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        lane_wdata = wdata_i;
        lane_be    = '1;
      end
    endcase
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (start_i) state_d = misaligned ? DONE : REQ;
      REQ:       if (dmem_ready_i) state_d = req_q.we ? DONE : WAIT_RESP;
      WAIT_RESP: if (dmem_rvalid_i) state_d = DONE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= IDLE;
      misaligned_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (launch)
        misaligned_q <= misaligned;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (launch)
    begin
      req_q   <= '{addr: addr, wdata: is_store ? lane_wdata : '0, be: lane_be,
                   we: is_store, size: size};
      op_q    <= op_i;
      rdata_q <= '0;
    end
    else if (state_q == WAIT_RESP && dmem_rvalid_i)
      rdata_q <= load_extract(op_q, req_q.addr[1:0], dmem_rdata_i);
  end

  assign done_o       = state_q == DONE;
  assign misaligned_o = misaligned_q;
  assign rdata_o      = rdata_q;
  assign dmem_valid_o = state_q == REQ;
  assign dmem_req_o   = req_q;

endmodule

`default_nettype wire

//--- hw/ex_mem_pkg.sv
/*
 * Data-memory port definitions: access sizes, request record, alignment rule
 */

`default_nettype none

package ex_mem_pkg;

  import ex_isa_pkg::*;

  localparam int unsigned DMEM_WORD_BYTES = 4;

  typedef logic [DMEM_WORD_BYTES-1:0] dmem_be_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  typedef struct packed {
    addr_t     addr;
    xlen_t     wdata;
    dmem_be_t  be;
    logic      we;
    mem_size_e size;
  } dmem_req_t;

  // Half needs bit 0 clear, word needs bits 1:0 clear
  function automatic logic is_misaligned(addr_t addr, mem_size_e size);
    case (size)
      SIZE_HALF: return addr[0];
      SIZE_WORD: return |addr[1:0];
      default:   return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hw/ex_stage.sv
/*
 * RV32I execute stage: operand bypass, ALU, branch and load/store units,
 * single-entry result register with valid/ready on both sides
 */

`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_isa_pkg::*;
  import ex_mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        id_valid_i,
  output logic        id_ready_o,
  input  ex_decoded_t id_op_i,
  input  xlen_t       rf_a_i,
  input  xlen_t       rf_b_i,
  output logic        ex_valid_o,
  input  logic        ex_ready_i,
  output ex_result_t  ex_result_o,
  output logic        bu_flush_o,
  output addr_t       bu_nxt_pc_o,
  output logic        dmem_valid_o,
  input  logic        dmem_ready_i,
  output dmem_req_t   dmem_req_o,
  input  logic        dmem_rvalid_i,
  input  xlen_t       dmem_rdata_i
);

  logic        live_q;
  logic        busy_q;
  logic        out_valid_q;
  logic        taken_q;
  ex_decoded_t op_q;
  xlen_t       a_q;
  xlen_t       b_q;
  ex_result_t  out_q;
  addr_t       target_q;
  xlen_t       last_value_q;
  xlen_t       prev_value;
  xlen_t       opnd_a;
  xlen_t       opnd_b;
  logic        accept;
  logic        out_fire;
  logic        unit_fin;
  logic        lsu_start;
  ex_unit_e    unit_sel;
  xlen_t       unit_value;
  xlen_t       alu_r;
  logic        bu_taken;
  addr_t       bu_target;
  xlen_t       bu_link;
  logic        lsu_done;
  logic        lsu_misaligned;
  xlen_t       lsu_rdata;

  ////////////////////////////////////////////////////////////
  // Handshakes and operand select
  ////////////////////////////////////////////////////////////

  assign out_fire   = out_valid_q & ex_ready_i;
  // One operation in flight; take the next as the result leaves
  assign id_ready_o = live_q & ~busy_q & (~out_valid_q | ex_ready_i);
  assign accept     = id_valid_i & id_ready_o;

  // Record leaving this cycle counts as the previous result
  assign prev_value = out_fire ? out_q.value : last_value_q;
  assign opnd_a     = id_op_i.bypass_a ? prev_value : rf_a_i;

  always_comb
  begin
    if (id_op_i.bypass_b)
      opnd_b = prev_value;
    else if (id_op_i.use_imm_b)
      opnd_b = id_op_i.imm;
    else
      opnd_b = rf_b_i;
  end

  assign lsu_start = accept & (ex_unit_of(id_op_i.op) == UNIT_LSU);
  assign unit_sel  = ex_unit_of(op_q.op);
  assign unit_fin  = busy_q & ((unit_sel != UNIT_LSU) | lsu_done);

  ////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i ( op_q.op ),
    .a_i  ( a_q     ),
    .b_i  ( b_q     ),
    .r_o  ( alu_r   )
  );

  ex_branch u_branch (
    .op_i     ( op_q.op   ),
    .pc_i     ( op_q.pc   ),
    .imm_i    ( op_q.imm  ),
    .a_i      ( a_q       ),
    .b_i      ( b_q       ),
    .taken_o  ( bu_taken  ),
    .target_o ( bu_target ),
    .link_o   ( bu_link   )
  );

  // Memory ops start straight from the accepted inputs
  ex_lsu u_lsu (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .start_i       ( lsu_start      ),
    .op_i          ( id_op_i.op     ),
    .base_i        ( opnd_a         ),
    .offset_i      ( id_op_i.imm    ),
    .wdata_i       ( opnd_b         ),
    .done_o        ( lsu_done       ),
    .misaligned_o  ( lsu_misaligned ),
    .rdata_o       ( lsu_rdata      ),
    .dmem_valid_o  ( dmem_valid_o   ),
    .dmem_ready_i  ( dmem_ready_i   ),
    .dmem_req_o    ( dmem_req_o     ),
    .dmem_rvalid_i ( dmem_rvalid_i  ),
    .dmem_rdata_i  ( dmem_rdata_i   )
  );

  always_comb
  begin
    case (unit_sel)
      UNIT_ALU:    unit_value = alu_r;
      UNIT_BRANCH: unit_value = bu_link;
      default:     unit_value = lsu_rdata;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State and output record
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      live_q       <= 1'b0;
      busy_q       <= 1'b0;
      out_valid_q  <= 1'b0;
      taken_q      <= 1'b0;
      last_value_q <= '0;
    end
    else
    begin
      live_q <= 1'b1;
      if (accept)
        busy_q <= 1'b1;
      else if (unit_fin)
        busy_q <= 1'b0;
      if (unit_fin)
      begin
        out_valid_q <= 1'b1;
        taken_q     <= (unit_sel == UNIT_BRANCH) & bu_taken;
      end
      else if (out_fire)
        out_valid_q <= 1'b0;
      if (out_fire)
        last_value_q <= out_q.value;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_q <= id_op_i;
      a_q  <= opnd_a;
      b_q  <= opnd_b;
    end
    if (unit_fin)
    begin
      out_q    <= '{value: unit_value, rd: op_q.rd, pc: op_q.pc,
                    misaligned: (unit_sel == UNIT_LSU) & lsu_misaligned};
      target_q <= bu_target;
    end
  end

  assign ex_valid_o  = out_valid_q;
  assign ex_result_o = out_q;
  // Redirect rides with its record and holds under back-pressure
  assign bu_flush_o  = out_valid_q & taken_q;
  assign bu_nxt_pc_o = target_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage simulation with Verilator

set -u

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
TOP=ex_stage_tb

verilator --binary --timing --assert \
  --top-module "${TOP}" \
  --Mdir "${OBJ_DIR}" \
  -o "V${TOP}" \
  -f ex_stage.f
status=$?
if [ ${status} -ne 0 ]; then
  echo "Verilator build failed with status ${status}"
  exit ${status}
fi

"./${OBJ_DIR}/V${TOP}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "Simulation failed with status ${status}"
  exit ${status}
fi

exit 0

//--- test/ex_stage_properties.sv
/*
 * Handshake and reset properties for the execute stage
 */

`timescale 1ns/1ps
`default_nettype none

module ex_stage_properties
  import ex_isa_pkg::*;
  import ex_mem_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       ex_valid_o,
  input logic       ex_ready_i,
  input ex_result_t ex_result_o,
  input logic       bu_flush_o,
  input addr_t      bu_nxt_pc_o,
  input logic       dmem_valid_o,
  input logic       dmem_ready_i,
  input dmem_req_t  dmem_req_o
);

  // Output record holds until taken
  a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_result_o))
    else $error("result record changed or dropped while stalled");

  // Memory request holds until accepted
  a_dmem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_valid_o && !dmem_ready_i |=> dmem_valid_o && $stable(dmem_req_o))
    else $error("memory request changed or dropped before ready");

  // Redirect and its target stay with a stalled record
  a_flush_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu_flush_o && !ex_ready_i |=> bu_flush_o && ex_valid_o && $stable(bu_nxt_pc_o))
    else $error("redirect changed or dropped while stalled");

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !ex_valid_o && !dmem_valid_o && !bu_flush_o)
    else $error("stage outputs active during reset");

endmodule

`default_nettype wire

//--- test/ex_stage_tb.sv
/*
 * Execute stage testbench: random operation stream, memory model and
 * reference model checked on every output transfer
 */

`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
  import ex_isa_pkg::*;
  import ex_mem_pkg::*;
();

  typedef struct packed {
    ex_result_t res;
    logic       flush;
    addr_t      target;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        id_valid;
  logic        id_ready;
  ex_decoded_t id_op;
  xlen_t       rf_a;
  xlen_t       rf_b;
  logic        ex_valid;
  logic        ex_ready;
  ex_result_t  ex_result;
  logic        bu_flush;
  addr_t       bu_nxt_pc;
  logic        dmem_valid;
  logic        dmem_ready;
  dmem_req_t   dmem_req;
  logic        dmem_rvalid;
  xlen_t       dmem_rdata;

  expect_t     expq[$];
  xlen_t       mem[64];
  xlen_t       ref_mem[64];
  xlen_t       prev_val;
  addr_t       pc_ctr;
  int unsigned accept_cnt;
  logic        drive_mis;
  logic        inflight_mis;
  addr_t       drive_addr;
  addr_t       inflight_addr;
  mem_size_e   drive_size;
  mem_size_e   inflight_size;
  logic        rd_pending;
  logic [5:0]  rd_idx;
  int          rd_delay;

  tb_clock_gen u_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  ex_stage u_ex_stage (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .id_valid_i    ( id_valid    ),
    .id_ready_o    ( id_ready    ),
    .id_op_i       ( id_op       ),
    .rf_a_i        ( rf_a        ),
    .rf_b_i        ( rf_b        ),
    .ex_valid_o    ( ex_valid    ),
    .ex_ready_i    ( ex_ready    ),
    .ex_result_o   ( ex_result   ),
    .bu_flush_o    ( bu_flush    ),
    .bu_nxt_pc_o   ( bu_nxt_pc   ),
    .dmem_valid_o  ( dmem_valid  ),
    .dmem_ready_i  ( dmem_ready  ),
    .dmem_req_o    ( dmem_req    ),
    .dmem_rvalid_i ( dmem_rvalid ),
    .dmem_rdata_i  ( dmem_rdata  )
  );

  bind ex_stage ex_stage_properties u_properties (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input xlen_t got, input xlen_t exp);
    assert (got == exp)
    else
      abort_run($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic xlen_t alu_ref(ex_op_e op, xlen_t a, xlen_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return $unsigned($signed(a) >>> b[4:0]);
      SLT:     return {31'b0, ($signed(a) < $signed(b))};
      default: return {31'b0, (a < b)};
    endcase
  endfunction

  function automatic logic cond_ref(ex_op_e op, xlen_t a, xlen_t b);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  task automatic predict(input ex_decoded_t d, input xlen_t ra, input xlen_t rb);
    expect_t e;
    xlen_t   a;
    xlen_t   b;
    addr_t   ad;
    xlen_t   sh;
    int      nb;
    int      off;
    e = '0;
    a = d.bypass_a ? prev_val : ra;
    b = d.bypass_b ? prev_val : (d.use_imm_b ? d.imm : rb);
    e.res.rd = d.rd;
    e.res.pc = d.pc;
    if (d.op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU})
      e.res.value = alu_ref(d.op, a, b);
    else if (d.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR})
    begin
      e.res.value = d.pc + 32'd4;
      e.flush     = cond_ref(d.op, a, b);
      e.target    = (d.op == JALR) ? ((a + d.imm) & ~32'd1) : d.pc + d.imm;
    end
    else
    begin
      ad  = a + d.imm;
      off = int'(ad[1:0]);
      nb  = (d.op inside {LB, LBU, SB}) ? 1 : (d.op inside {LH, LHU, SH}) ? 2 : 4;
      drive_addr = ad;
      drive_size = (nb == 1) ? SIZE_BYTE : (nb == 2) ? SIZE_HALF : SIZE_WORD;
      e.res.misaligned = (nb == 2 && ad[0]) || (nb == 4 && ad[1:0] != 2'b00);
      if (!e.res.misaligned && d.op inside {SB, SH, SW})
      begin
        for (int k = off; k < off + nb; k++)
          ref_mem[ad[7:2]][8*k +: 8] = b[8*(k-off) +: 8];
      end
      else if (!e.res.misaligned)
      begin
        sh = ref_mem[ad[7:2]] >> (8 * off);
        case (d.op)
          LB:      e.res.value = {{24{sh[7]}}, sh[7:0]};
          LBU:     e.res.value = {24'b0, sh[7:0]};
          LH:      e.res.value = {{16{sh[15]}}, sh[15:0]};
          LHU:     e.res.value = {16'b0, sh[15:0]};
          default: e.res.value = sh;
        endcase
      end
    end
    prev_val  = e.res.value;
    drive_mis = e.res.misaligned;
    expq.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model, back-pressure and output monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    dmem_rvalid = 1'b0;
    if (rd_pending && rd_delay == 0)
    begin
      dmem_rvalid = 1'b1;
      dmem_rdata  = mem[rd_idx];
      rd_pending  = 1'b0;
    end
    else if (rd_pending)
      rd_delay = rd_delay - 1;
    dmem_ready = ($urandom % 3) == 0;
    ex_ready   = ($urandom % 4) != 0;
    // Request is taken at the coming rising edge
    if (rst_n && dmem_valid && dmem_ready)
    begin
      check_field("dmem_req_o.addr", dmem_req.addr, inflight_addr);
      check_field("dmem_req_o.size", {30'b0, dmem_req.size}, {30'b0, inflight_size});
      if (dmem_req.we)
      begin
        for (int k = 0; k < 4; k++)
          if (dmem_req.be[k])
            mem[dmem_req.addr[7:2]][8*k +: 8] = dmem_req.wdata[8*k +: 8];
      end
      else
      begin
        rd_pending = 1'b1;
        rd_idx     = dmem_req.addr[7:2];
        rd_delay   = int'($urandom % 4);
      end
    end
  end

  always @(posedge clk)
  begin
    expect_t e;
    if (rst_n)
    begin
      if (dmem_valid)
        assert (!inflight_mis)
        else
          abort_run("memory request issued for a misaligned access");
      if (id_valid && id_ready)
      begin
        inflight_mis  = drive_mis;
        inflight_addr = drive_addr;
        inflight_size = drive_size;
        accept_cnt    = accept_cnt + 1;
      end
      if (ex_valid && ex_ready)
      begin
        if (expq.size() == 0)
          abort_run("output record arrived with nothing expected");
        e = expq.pop_front();
        check_field("ex_result_o.value", ex_result.value, e.res.value);
        check_field("ex_result_o.rd", {27'b0, ex_result.rd}, {27'b0, e.res.rd});
        check_field("ex_result_o.pc", ex_result.pc, e.res.pc);
        check_field("ex_result_o.misaligned", {31'b0, ex_result.misaligned},
                    {31'b0, e.res.misaligned});
        check_field("bu_flush_o", {31'b0, bu_flush}, {31'b0, e.flush});
        if (e.flush)
          check_field("bu_nxt_pc_o", bu_nxt_pc, e.target);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic ex_decoded_t make_op(ex_op_e op, xlen_t imm, logic use_imm,
                                          logic ba, logic bb);
    ex_decoded_t d;
    d.op        = op;
    d.pc        = pc_ctr;
    d.imm       = imm;
    d.rd        = reg_idx_t'($urandom % 32);
    d.use_imm_b = use_imm;
    d.bypass_a  = ba;
    d.bypass_b  = bb;
    pc_ctr      = pc_ctr + 32'd4;
    return d;
  endfunction

  task automatic send_op(input ex_decoded_t d, input xlen_t ra, input xlen_t rb);
    int unsigned start_cnt;
    int          waited;
    predict(d, ra, rb);
    start_cnt = accept_cnt;
    id_valid  = 1'b1;
    id_op     = d;
    rf_a      = ra;
    rf_b      = rb;
    waited    = 0;
    while (accept_cnt == start_cnt)
    begin
      @(negedge clk);
      waited++;
      if (waited > 300)
        abort_run("decode handshake timed out");
    end
    id_valid = 1'b0;
  endtask

  ex_op_e alu_ops[10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
  ex_op_e br_ops[8]   = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR};
  ex_op_e mem_ops[8]  = '{LB, LH, LW, LBU, LHU, SB, SH, SW};

  initial
  begin
    int    waited;
    xlen_t a;
    void'($urandom(69596));
    id_valid      = 1'b0;
    id_op         = '0;
    rf_a          = '0;
    rf_b          = '0;
    ex_ready      = 1'b0;
    dmem_ready    = 1'b0;
    dmem_rvalid   = 1'b0;
    dmem_rdata    = '0;
    prev_val      = '0;
    pc_ctr        = 32'h0000_1000;
    accept_cnt    = 0;
    drive_mis     = 1'b0;
    inflight_mis  = 1'b0;
    drive_addr    = '0;
    inflight_addr = '0;
    drive_size    = SIZE_BYTE;
    inflight_size = SIZE_BYTE;
    rd_pending    = 1'b0;
    rd_idx        = '0;
    rd_delay      = 0;
    // Fill pattern mixes every address bit
    for (int i = 0; i < 64; i++)
    begin
      mem[i]     = (i * 32'h9E37_79B9) ^ 32'h5A3C_0F00 ^ (i << 20);
      ref_mem[i] = mem[i];
    end
    waited = 0;
    while (rst_n !== 1'b1)
    begin
      @(negedge clk);
      waited++;
      if (waited > 100)
        abort_run("reset never released");
    end
    @(negedge clk);

    // ALU with register and immediate operand B
    foreach (alu_ops[i])
      for (int j = 0; j < 6; j++)
      begin
        a = $urandom;
        send_op(make_op(alu_ops[i], $urandom, j[0], 1'b0, 1'b0), a,
                (j == 2) ? a : $urandom);
      end

    // Branches, jumps and equal operands
    foreach (br_ops[i])
      for (int j = 0; j < 6; j++)
      begin
        a = $urandom;
        send_op(make_op(br_ops[i], $urandom % 512, 1'b0, 1'b0, 1'b0), a,
                j[0] ? a : $urandom);
      end

    // Every access size with random lane offsets
    for (int j = 0; j < 80; j++)
      send_op(make_op(mem_ops[$urandom % 8], $urandom % 4, 1'b0, 1'b0, 1'b0),
              ($urandom % 64) * 4, $urandom);

    // Bypass chains after loads and ALU results
    for (int j = 0; j < 20; j++)
    begin
      send_op(make_op(LW, 32'd0, 1'b0, 1'b0, 1'b0), ($urandom % 64) * 4, '0);
      send_op(make_op(alu_ops[$urandom % 10], $urandom, 1'b0, 1'b1, j[0]),
              $urandom, $urandom);
      send_op(make_op(SW, ($urandom % 64) * 4, 1'b0, 1'b0, 1'b1), '0, $urandom);
    end

    // Mixed stream with idle gaps
    for (int j = 0; j < 150; j++)
    begin
      send_op(make_op(ex_op_e'(5'($urandom % 26)), $urandom % 256, 1'($urandom % 2),
                      1'($urandom % 2), 1'($urandom % 2)), ($urandom % 64) * 4, $urandom);
      if ($urandom % 5 == 0)
        repeat ($urandom % 4) @(negedge clk);
    end

    waited = 0;
    while (expq.size() != 0 && waited <= 300)
    begin
      @(negedge clk);
      waited++;
    end
    if (expq.size() == 0)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
      abort_run("expected records still pending at end of run");
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
/*
 * Testbench clock and reset source for the execute stage
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 16;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire
